// File: vlog.f
hw/core_pkg.sv
hw/apb_if.sv
hw/register_file.sv
hw/alu.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/exe_mem_wb_stage.sv
hw/core.sv
sim/apb_mem_model.sv
sim/tb_core.sv

// File: sim/tb_core.sv
`timescale 1ns/1ps

module tb_core;

	localparam int NROWS = 6;
	localparam int MAX_WORDS = 12;
	localparam int RESET_CYCLES = 16;
	localparam int NRUNS = 2 * NROWS;
	// each run gets 20 cycles per instruction slot plus its reset
	localparam int MAX_CYCLES = NRUNS * (MAX_WORDS * 20 + RESET_CYCLES);

	logic clk = 1'b0;
	logic arst_n_i;
	logic rand_wait;
	logic halted_o;

	apb_if imem_bus ();
	apb_if dmem_bus ();

	// program table
	string       row_name [NROWS];
	logic [31:0] row_prog [NROWS][MAX_WORDS];
	logic [31:0] row_addr [NROWS];
	logic [15:0] row_data [NROWS];
	int          cur_row;
	int          cur_len;

	// last dmem write
	logic        store_seen;
	logic [31:0] store_addr;
	logic [15:0] store_data;

	int err_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	int cycle_count = 0;

	always #50 clk = ~clk;

	core u_core (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.imem_apb_o(imem_bus),
		.dmem_apb_o(dmem_bus),
		.halted_o(halted_o)
	);

	apb_mem_model u_imem (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.rand_wait_i(rand_wait),
		.apb_i(imem_bus)
	);

	apb_mem_model u_dmem (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.rand_wait_i(rand_wait),
		.apb_i(dmem_bus)
	);

	always @(posedge clk) begin
		if (!arst_n_i) begin
			store_seen <= 1'b0;
		end else if (dmem_bus.psel && dmem_bus.penable && dmem_bus.pready
				&& dmem_bus.pwrite) begin
			store_seen <= 1'b1;
			store_addr <= dmem_bus.paddr;
			store_data <= dmem_bus.pwdata[15:0];
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > MAX_CYCLES) begin
			$display("halt was never reached within %0d cycles", MAX_CYCLES);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic logic [31:0] r_word(core_pkg::opcode_e op, int rd, int rs1, int rs2);
		return {op, 4'(rd), 4'(rs1), 4'(rs2), 14'd0};
	endfunction

	function automatic logic [31:0] i_word(core_pkg::opcode_e op, int rd, int rs1,
			logic [15:0] imm);
		return {op, 4'(rd), 4'(rs1), 2'b00, imm};
	endfunction

	task automatic start_row(input int r, input string name, input logic [31:0] addr,
			input logic [15:0] data);
		cur_row = r;
		cur_len = 0;
		row_name[r] = name;
		row_addr[r] = addr;
		row_data[r] = data;
	endtask

	task automatic put(input logic [31:0] w);
		row_prog[cur_row][cur_len] = w;
		cur_len++;
	endtask

	task automatic build_table();
		for (int r = 0; r < NROWS; r++) begin
			for (int w = 0; w < MAX_WORDS; w++) begin
				row_prog[r][w] = r_word(core_pkg::OP_HALT, 0, 0, 0);
			end
		end
		start_row(0, "alu", 32'h40, ((((16'h1234 + 16'hff00) & (16'h1234 - 16'hff00))
			| 16'hff00) ^ (16'h1234 - 16'hff00)));
		put(i_word(core_pkg::OP_ADDI, 1, 0, 16'h1234));
		put(i_word(core_pkg::OP_ADDI, 2, 0, 16'hff00));
		put(r_word(core_pkg::OP_ADD, 3, 1, 2));
		put(r_word(core_pkg::OP_SUB, 4, 1, 2));
		put(r_word(core_pkg::OP_AND, 5, 3, 4));
		put(r_word(core_pkg::OP_OR, 6, 5, 2));
		put(r_word(core_pkg::OP_XOR, 7, 6, 4));
		put(i_word(core_pkg::OP_SW, 7, 0, 16'h0040));
		// shift amounts 0, 1 and 15 taken from the low nibble of rs2
		start_row(1, "shifts", 32'h44, ((16'h8421 << 0) >> 1) ^ (16'h8421 << 15)
			^ (16'h8421 >> 15));
		put(i_word(core_pkg::OP_ADDI, 1, 0, 16'h8421));
		put(i_word(core_pkg::OP_ADDI, 2, 0, 16'h0000));
		put(r_word(core_pkg::OP_SLL, 3, 1, 2));
		put(i_word(core_pkg::OP_ADDI, 2, 0, 16'h0011));
		put(r_word(core_pkg::OP_SRL, 4, 3, 2));
		put(i_word(core_pkg::OP_ADDI, 2, 0, 16'h002f));
		put(r_word(core_pkg::OP_SLL, 5, 1, 2));
		put(r_word(core_pkg::OP_SRL, 6, 1, 2));
		put(r_word(core_pkg::OP_XOR, 7, 4, 5));
		put(r_word(core_pkg::OP_XOR, 7, 7, 6));
		put(i_word(core_pkg::OP_SW, 7, 0, 16'h0044));
		start_row(2, "load_store", 32'h84, 16'h5a3c);
		put(i_word(core_pkg::OP_ADDI, 1, 0, 16'h5a3c));
		put(i_word(core_pkg::OP_ADDI, 2, 0, 16'h0080));
		put(i_word(core_pkg::OP_SW, 1, 2, 16'h0000));
		put(i_word(core_pkg::OP_LW, 3, 2, 16'h0000));
		put(i_word(core_pkg::OP_SW, 3, 2, 16'h0004));
		// first beq skips the +1, second one falls through to the +4
		start_row(3, "beq", 32'h48, 16'h0010 + 16'h0004);
		put(i_word(core_pkg::OP_ADDI, 1, 0, 16'h0007));
		put(i_word(core_pkg::OP_ADDI, 2, 0, 16'h0007));
		put(i_word(core_pkg::OP_ADDI, 3, 0, 16'h0010));
		put(i_word(core_pkg::OP_BEQ, 1, 2, 16'h0001));
		put(i_word(core_pkg::OP_ADDI, 3, 3, 16'h0001));
		put(i_word(core_pkg::OP_ADDI, 2, 2, 16'h0001));
		put(i_word(core_pkg::OP_BEQ, 1, 2, 16'h0001));
		put(i_word(core_pkg::OP_ADDI, 3, 3, 16'h0004));
		put(i_word(core_pkg::OP_SW, 3, 0, 16'h0048));
		// backward bne at pc 16 lands on pc 8, three passes
		start_row(4, "bne_loop", 32'h50, 16'd3 * 16'd5);
		put(i_word(core_pkg::OP_ADDI, 1, 0, 16'h0003));
		put(i_word(core_pkg::OP_ADDI, 2, 0, 16'h0000));
		put(i_word(core_pkg::OP_ADDI, 2, 2, 16'h0005));
		put(i_word(core_pkg::OP_ADDI, 1, 1, 16'hffff));
		put(i_word(core_pkg::OP_BNE, 1, 0, 16'hfffd));
		put(i_word(core_pkg::OP_SW, 2, 0, 16'h0050));
		// jump to pc 12 over the poison, then r0 stored at the base in r1
		start_row(5, "jmp_r0", 32'h70, 16'h0000);
		put(i_word(core_pkg::OP_ADDI, 1, 0, 16'h0070));
		put(i_word(core_pkg::OP_JMP, 0, 0, 16'h0003));
		put(i_word(core_pkg::OP_ADDI, 1, 0, 16'h0bc0));
		put(i_word(core_pkg::OP_ADDI, 0, 0, 16'h0055));
		put(i_word(core_pkg::OP_SW, 0, 1, 16'h0000));
	endtask

	task automatic load_program(input int r);
		// halt everywhere, low bits carry the word address
		for (int a = 0; a < 256; a++) begin
			u_imem.mem[a] = {core_pkg::OP_HALT, 26'(a)};
		end
		for (int w = 0; w < MAX_WORDS; w++) begin
			u_imem.mem[w] = row_prog[r][w];
		end
		// fresh data memory so a load never sees an earlier run's store
		for (int a = 0; a < 256; a++) begin
			u_dmem.mem[a] = {16'ha5a5 ^ 16'(a), 16'(a * 4)};
		end
	endtask

	task automatic check_value(input string sig, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, sig, exp, act);
			err_count++;
		end
	endtask

	task automatic run_row(input int r, input logic waits);
		int errs_before;
		errs_before = err_count;
		@(negedge clk);
		arst_n_i = 1'b0;
		rand_wait = waits;
		load_program(r);
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n_i = 1'b1;
		while (!halted_o) begin
			@(negedge clk);
		end
		if (!store_seen) begin
			$display("test %s: core halted without any data store", row_name[r]);
			err_count++;
		end else begin
			check_value("dmem paddr", row_addr[r], store_addr);
			check_value("dmem pwdata", {16'd0, row_data[r]}, {16'd0, store_data});
		end
		if (err_count == errs_before) begin
			pass_count++;
			$display("test %-10s wait states %0d: ok", row_name[r], waits);
		end else begin
			fail_count++;
			$display("test %-10s wait states %0d: FAILED", row_name[r], waits);
		end
	endtask

	initial begin
		arst_n_i = 1'b0;
		rand_wait = 1'b0;
		build_table();
		// second round repeats every row with random wait states
		for (int round = 0; round < 2; round++) begin
			for (int r = 0; r < NROWS; r++) begin
				run_row(r, round[0]);
			end
		end
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: sim/apb_mem_model.sv
`timescale 1ns/1ps

module apb_mem_model (
	input  logic clk,
	input  logic arst_n_i,
	input  logic rand_wait_i,
	apb_if.slave apb_i
);

	localparam int DEPTH = 256;

	logic [31:0] mem [DEPTH];
	logic [31:0] prdata_q;
	logic        pready_q;
	logic [1:0]  wait_cnt;
	logic [7:0]  idx;
	integer      seed;

	// word index from the byte address
	assign idx = apb_i.paddr[9:2];

	initial begin
		seed = 32'hd544_c093;
		for (int a = 0; a < DEPTH; a++) begin
			mem[a] = {16'h5a5a ^ 16'(a), 16'(a * 4)};
		end
	end

	always @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pready_q <= 1'b0;
			wait_cnt <= '0;
		end else if (pready_q) begin
			// transfer ends on this edge
			pready_q <= 1'b0;
		end else if (apb_i.psel && !apb_i.penable) begin
			wait_cnt <= rand_wait_i ? 2'($random(seed)) : 2'd0;
		end else if (apb_i.psel && apb_i.penable) begin
			if (wait_cnt == 2'd0) begin
				pready_q <= 1'b1;
				prdata_q <= mem[idx];
				if (apb_i.pwrite) begin
					mem[idx] <= apb_i.pwdata;
				end
			end else begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end
	end

	assign apb_i.pready = pready_q;
	assign apb_i.prdata = prdata_q;

endmodule

// File: hw/core.sv
`timescale 1ns/1ps

module core (
	input  logic  clk,
	input  logic  arst_n_i,
	apb_if.master imem_apb_o,
	apb_if.master dmem_apb_o,
	output logic  halted_o
);

	// fetch to decode
	logic                      fetch_valid;
	logic [core_pkg::ILEN-1:0] fetch_pc;
	logic [core_pkg::ILEN-1:0] fetch_inst;

	// decode outputs
	logic                      dec_ready;
	logic                      dec_valid;
	core_pkg::cs_exe_s         dec_cs_exe;
	logic                      dec_jmp;
	logic [core_pkg::ILEN-1:0] dec_jmp_target;

	// execute side channel
	logic                      exe_ready;
	logic                      exe_cmp_result_valid;
	logic                      exe_cmp_result;

	fetch_unit fetch (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.ready_i(dec_ready),
		.jmp_i(dec_jmp),
		.jmp_target_i(dec_jmp_target),
		.cmp_result_valid_i(exe_cmp_result_valid),
		.cmp_result_i(exe_cmp_result),
		.imem_apb_o(imem_apb_o),
		.valid_o(fetch_valid),
		.pc_o(fetch_pc),
		.inst_o(fetch_inst)
	);

	decode_unit decode (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.valid_i(fetch_valid),
		.inst_i(fetch_inst),
		.pc_i(fetch_pc),
		.ready_i(exe_ready),
		.ready_o(dec_ready),
		.valid_o(dec_valid),
		.cs_exe_o(dec_cs_exe),
		.pc_o(),
		.jmp_o(dec_jmp),
		.jmp_target_o(dec_jmp_target)
	);

	exe_mem_wb_stage exe_mem_wb (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.valid_i(dec_valid),
		.cs_i(dec_cs_exe),
		.dmem_apb_o(dmem_apb_o),
		.ready_o(exe_ready),
		.cmp_result_valid_o(exe_cmp_result_valid),
		.cmp_result_o(exe_cmp_result),
		.halted_o(halted_o)
	);

endmodule

// File: hw/exe_mem_wb_stage.sv
`timescale 1ns/1ps

module exe_mem_wb_stage (
	input  logic              clk,
	input  logic              arst_n_i,
	input  logic              valid_i,
	input  core_pkg::cs_exe_s cs_i,
	apb_if.master             dmem_apb_o,
	output logic              ready_o,
	output logic              cmp_result_valid_o,
	output logic              cmp_result_o,
	output logic              halted_o
);

	logic [core_pkg::XLEN-1:0]   rd1;
	logic [core_pkg::XLEN-1:0]   rd2;
	logic [core_pkg::XLEN-1:0]   alu_b;
	logic [core_pkg::XLEN-1:0]   alu_y;
	logic                        alu_eq;
	logic                        accept;
	logic                        mem_op;
	logic                        mem_done;
	logic                        we;
	logic [core_pkg::RIDX_W-1:0] wa;
	logic [core_pkg::XLEN-1:0]   wd;
	logic                        psel_q;
	logic                        penable_q;
	logic                        pwrite_q;
	logic [core_pkg::ILEN-1:0]   paddr_q;
	logic [core_pkg::XLEN-1:0]   wdata_q;
	logic [core_pkg::RIDX_W-1:0] ld_rd_q;
	logic                        halted_q;

	// busy for the whole data access
	assign ready_o = !psel_q && !halted_q;
	assign accept = valid_i && ready_o;
	assign mem_op = cs_i.load || cs_i.store;
	assign mem_done = psel_q && penable_q && dmem_apb_o.pready;
	assign alu_b = cs_i.use_imm ? cs_i.imm : rd2;

	// alu result at acceptance, load data at pready
	assign we = (accept && cs_i.reg_write && !mem_op) || (mem_done && !pwrite_q);
	assign wa = mem_done ? ld_rd_q : cs_i.rd;
	assign wd = mem_done ? dmem_apb_o.prdata[core_pkg::XLEN-1:0] : alu_y;

	assign cmp_result_valid_o = accept && (cs_i.branch_eq || cs_i.branch_ne);
	assign cmp_result_o = cs_i.branch_eq ? alu_eq : !alu_eq;

	register_file regs (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.rs1_i(cs_i.rs1),
		.rs2_i(cs_i.rs2),
		.we_i(we),
		.rd_i(wa),
		.wd_i(wd),
		.rd1_o(rd1),
		.rd2_o(rd2)
	);

	alu alu_i (
		.op_i(cs_i.alu_op),
		.a_i(rd1),
		.b_i(alu_b),
		.y_o(alu_y),
		.eq_o(alu_eq)
	);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			psel_q <= 1'b0;
			penable_q <= 1'b0;
			halted_q <= 1'b0;
		end else begin
			if (accept && mem_op) begin
				psel_q <= 1'b1;
			end else if (psel_q && !penable_q) begin
				penable_q <= 1'b1;
			end else if (mem_done) begin
				psel_q <= 1'b0;
				penable_q <= 1'b0;
			end
			if (accept && cs_i.halt) begin
				halted_q <= 1'b1;
			end
		end
	end

	// access parameters latched at acceptance
	always_ff @(posedge clk) begin
		if (accept && mem_op) begin
			pwrite_q <= cs_i.store;
			paddr_q <= {16'd0, alu_y};
			wdata_q <= rd2;
			ld_rd_q <= cs_i.rd;
		end
	end

	assign dmem_apb_o.psel = psel_q;
	assign dmem_apb_o.penable = penable_q;
	assign dmem_apb_o.pwrite = pwrite_q;
	assign dmem_apb_o.paddr = paddr_q;
	assign dmem_apb_o.pwdata = {16'd0, wdata_q};

	assign halted_o = halted_q;

endmodule

// File: hw/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  logic                      valid_i,
	input  logic [core_pkg::ILEN-1:0] inst_i,
	input  logic [core_pkg::ILEN-1:0] pc_i,
	input  logic                      ready_i,
	output logic                      ready_o,
	output logic                      valid_o,
	output core_pkg::cs_exe_s         cs_exe_o,
	output logic [core_pkg::ILEN-1:0] pc_o,
	output logic                      jmp_o,
	output logic [core_pkg::ILEN-1:0] jmp_target_o
);

	core_pkg::inst_u           inst;
	core_pkg::cs_exe_s         cs_d;
	core_pkg::cs_exe_s         cs_q;
	logic [core_pkg::ILEN-1:0] pc_q;
	logic [core_pkg::ILEN-1:0] jmp_target_q;
	logic                      valid_q;
	logic                      jmp_q;
	logic                      capture;
	logic                      is_jmp;

	assign inst = inst_i;
	assign is_jmp = (inst.i.opcode == core_pkg::OP_JMP);
	// free when empty or when execute takes the held entry this cycle
	assign ready_o = !valid_q || ready_i;
	assign capture = valid_i && ready_o;

	always_comb begin
		cs_d = '0;
		cs_d.alu_op = core_pkg::ALU_ADD;
		cs_d.rd = inst.r.rd;
		cs_d.rs1 = inst.r.rs1;
		cs_d.rs2 = inst.r.rs2;
		cs_d.imm = inst.i.imm;
		case (inst.r.opcode)
			core_pkg::OP_ADD: cs_d.reg_write = 1'b1;
			core_pkg::OP_SUB: begin
				cs_d.alu_op = core_pkg::ALU_SUB;
				cs_d.reg_write = 1'b1;
			end
			core_pkg::OP_AND: begin
				cs_d.alu_op = core_pkg::ALU_AND;
				cs_d.reg_write = 1'b1;
			end
			core_pkg::OP_OR: begin
				cs_d.alu_op = core_pkg::ALU_OR;
				cs_d.reg_write = 1'b1;
			end
			core_pkg::OP_XOR: begin
				cs_d.alu_op = core_pkg::ALU_XOR;
				cs_d.reg_write = 1'b1;
			end
			core_pkg::OP_SLL: begin
				cs_d.alu_op = core_pkg::ALU_SLL;
				cs_d.reg_write = 1'b1;
			end
			core_pkg::OP_SRL: begin
				cs_d.alu_op = core_pkg::ALU_SRL;
				cs_d.reg_write = 1'b1;
			end
			core_pkg::OP_ADDI: begin
				cs_d.use_imm = 1'b1;
				cs_d.reg_write = 1'b1;
			end
			core_pkg::OP_LW: begin
				cs_d.use_imm = 1'b1;
				cs_d.load = 1'b1;
				cs_d.reg_write = 1'b1;
			end
			// store data comes from rd on the second read port
			core_pkg::OP_SW: begin
				cs_d.use_imm = 1'b1;
				cs_d.store = 1'b1;
				cs_d.rs2 = inst.r.rd;
			end
			core_pkg::OP_BEQ: begin
				cs_d.branch_eq = 1'b1;
				cs_d.rs2 = inst.r.rd;
			end
			core_pkg::OP_BNE: begin
				cs_d.branch_ne = 1'b1;
				cs_d.rs2 = inst.r.rd;
			end
			core_pkg::OP_HALT: cs_d.halt = 1'b1;
			default: cs_d.reg_write = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= 1'b0;
			jmp_q <= 1'b0;
		end else begin
			jmp_q <= capture && is_jmp;
			if (capture) begin
				// jumps end here
				valid_q <= !is_jmp;
			end else if (ready_i) begin
				valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			cs_q <= cs_d;
			pc_q <= pc_i;
			jmp_target_q <= {14'd0, inst.i.imm, 2'b00};
		end
	end

	assign valid_o = valid_q;
	assign cs_exe_o = cs_q;
	assign pc_o = pc_q;
	assign jmp_o = jmp_q;
	assign jmp_target_o = jmp_target_q;

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  logic                      ready_i,
	input  logic                      jmp_i,
	input  logic [core_pkg::ILEN-1:0] jmp_target_i,
	input  logic                      cmp_result_valid_i,
	input  logic                      cmp_result_i,
	apb_if.master                     imem_apb_o,
	output logic                      valid_o,
	output logic [core_pkg::ILEN-1:0] pc_o,
	output logic [core_pkg::ILEN-1:0] inst_o
);

	logic [core_pkg::ILEN-1:0] pc_q;
	logic [core_pkg::ILEN-1:0] inst_q;
	logic [core_pkg::ILEN-1:0] br_target_q;
	logic                      valid_q;
	logic                      wait_q;
	logic                      stop_q;
	logic                      psel_q;
	logic                      penable_q;
	core_pkg::inst_u           held;
	logic                      handover;
	logic                      issue;
	logic                      rd_done;
	logic                      is_redirect;

	assign held = inst_q;
	assign handover = valid_q && ready_i;
	assign rd_done = psel_q && penable_q && imem_apb_o.pready;
	// no new read while holding a word, waiting on a redirect or halted
	assign issue = !valid_q && !wait_q && !stop_q && !psel_q;
	assign is_redirect = (held.i.opcode == core_pkg::OP_BEQ) ||
	                     (held.i.opcode == core_pkg::OP_BNE) ||
	                     (held.i.opcode == core_pkg::OP_JMP);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q <= '0;
			valid_q <= 1'b0;
			wait_q <= 1'b0;
			stop_q <= 1'b0;
			psel_q <= 1'b0;
			penable_q <= 1'b0;
		end else begin
			// apb read sequence, setup then access until pready
			if (issue) begin
				psel_q <= 1'b1;
			end else if (psel_q && !penable_q) begin
				penable_q <= 1'b1;
			end else if (rd_done) begin
				psel_q <= 1'b0;
				penable_q <= 1'b0;
				valid_q <= 1'b1;
			end
			if (handover) begin
				valid_q <= 1'b0;
				if (is_redirect) begin
					wait_q <= 1'b1;
				end else if (held.i.opcode == core_pkg::OP_HALT) begin
					stop_q <= 1'b1;
				end else begin
					pc_q <= pc_q + 32'd4;
				end
			end
			// redirect from decode or from execute
			if (wait_q && jmp_i) begin
				pc_q <= jmp_target_i;
				wait_q <= 1'b0;
			end else if (wait_q && cmp_result_valid_i) begin
				pc_q <= cmp_result_i ? br_target_q : pc_q + 32'd4;
				wait_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_done) begin
			inst_q <= imem_apb_o.prdata;
		end
		if (handover) begin
			// pc+4 plus sign-extended word offset
			br_target_q <= pc_q + 32'd4 + {{14{held.i.imm[15]}}, held.i.imm, 2'b00};
		end
	end

	assign imem_apb_o.psel = psel_q;
	assign imem_apb_o.penable = penable_q;
	assign imem_apb_o.pwrite = 1'b0;
	assign imem_apb_o.paddr = pc_q;
	assign imem_apb_o.pwdata = '0;

	assign valid_o = valid_q;
	assign pc_o = pc_q;
	assign inst_o = inst_q;

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
	input  core_pkg::alu_op_e         op_i,
	input  logic [core_pkg::XLEN-1:0] a_i,
	input  logic [core_pkg::XLEN-1:0] b_i,
	output logic [core_pkg::XLEN-1:0] y_o,
	output logic                      eq_o
);

	logic [3:0] shamt;

	// shift amount from low bits of b only
	assign shamt = b_i[3:0];

	always_comb begin
		case (op_i)
			core_pkg::ALU_ADD: y_o = a_i + b_i;
			core_pkg::ALU_SUB: y_o = a_i - b_i;
			core_pkg::ALU_AND: y_o = a_i & b_i;
			core_pkg::ALU_OR:  y_o = a_i | b_i;
			core_pkg::ALU_XOR: y_o = a_i ^ b_i;
			core_pkg::ALU_SLL: y_o = a_i << shamt;
			core_pkg::ALU_SRL: y_o = a_i >> shamt;
			default:           y_o = '0;
		endcase
	end

	// branch compare
	assign eq_o = (a_i == b_i);

endmodule

// File: hw/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                        clk,
	input  logic                        arst_n_i,
	input  logic [core_pkg::RIDX_W-1:0] rs1_i,
	input  logic [core_pkg::RIDX_W-1:0] rs2_i,
	input  logic                        we_i,
	input  logic [core_pkg::RIDX_W-1:0] rd_i,
	input  logic [core_pkg::XLEN-1:0]   wd_i,
	output logic [core_pkg::XLEN-1:0]   rd1_o,
	output logic [core_pkg::XLEN-1:0]   rd2_o
);

	logic [core_pkg::XLEN-1:0] regs [core_pkg::NREG];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < core_pkg::NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (rd_i != '0)) begin
			regs[rd_i] <= wd_i;
		end
	end

	// r0 never written, reads back zero
	assign rd1_o = regs[rs1_i];
	assign rd2_o = regs[rs2_i];

endmodule

// File: hw/apb_if.sv
`timescale 1ns/1ps

interface apb_if;

	logic                       psel;
	logic                       penable;
	logic                       pwrite;
	logic [core_pkg::ILEN-1:0]  paddr;
	logic [core_pkg::ILEN-1:0]  pwdata;
	logic [core_pkg::ILEN-1:0]  prdata;
	logic                       pready;

	modport master (
		output psel,
		output penable,
		output pwrite,
		output paddr,
		output pwdata,
		input  prdata,
		input  pready
	);

	// memory side, answers with data and wait states
	modport slave (
		input  psel,
		input  penable,
		input  pwrite,
		input  paddr,
		input  pwdata,
		output prdata,
		output pready
	);

endinterface

// File: hw/core_pkg.sv
package core_pkg;

	// register data width
	localparam int XLEN = 16;
	// instruction word and address width
	localparam int ILEN = 32;
	localparam int NREG = 16;
	localparam int RIDX_W = $clog2(NREG);

	typedef enum logic [5:0] {
		OP_ADD  = 6'h00,
		OP_SUB  = 6'h01,
		OP_AND  = 6'h02,
		OP_OR   = 6'h03,
		OP_XOR  = 6'h04,
		OP_SLL  = 6'h05,
		OP_SRL  = 6'h06,
		OP_ADDI = 6'h08,
		OP_LW   = 6'h10,
		OP_SW   = 6'h11,
		OP_BEQ  = 6'h18,
		OP_BNE  = 6'h19,
		OP_JMP  = 6'h1a,
		OP_HALT = 6'h3f
	} opcode_e;

	// register-register view
	typedef struct packed {
		opcode_e           opcode;
		logic [RIDX_W-1:0] rd;
		logic [RIDX_W-1:0] rs1;
		logic [RIDX_W-1:0] rs2;
		logic [13:0]       unused;
	} inst_r_s;

	// immediate view, bits 17..16 are spare
	typedef struct packed {
		opcode_e           opcode;
		logic [RIDX_W-1:0] rd;
		logic [RIDX_W-1:0] rs1;
		logic [1:0]        spare;
		logic [15:0]       imm;
	} inst_i_s;

	typedef union packed {
		inst_r_s r;
		inst_i_s i;
	} inst_u;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL
	} alu_op_e;

	typedef struct packed {
		alu_op_e           alu_op;
		logic              use_imm;
		logic              load;
		logic              store;
		logic              reg_write;
		logic              branch_eq;
		logic              branch_ne;
		logic              halt;
		logic [RIDX_W-1:0] rd;
		logic [RIDX_W-1:0] rs1;
		logic [RIDX_W-1:0] rs2;
		logic [XLEN-1:0]   imm;
	} cs_exe_s;

endpackage
